//--- include/llc_tag_params.svh
// size macros for the tag store: way count, set index width, tag width
`ifndef LLC_TAG_PARAMS_SVH
`define LLC_TAG_PARAMS_SVH

// ----------------------------------------
// cache geometry
// ----------------------------------------

// number of ways in one set
`define LLC_WAYS 4

// set index width, 16 sets
`define LLC_INDEX_W 4

// stored tag width
`define LLC_TAG_W 8

`endif

//--- src/llc_tag_pkg.sv
// tag store types: request mode and decode state enums, entry struct, way vector
`default_nettype none

`include "llc_tag_params.svh"

package llc_tag_pkg;

  // ----------------------------------------
  // field types
  // ----------------------------------------

  // one bit per way, also used as a one-hot way select
  typedef logic [`LLC_WAYS-1:0] way_t;

  // set index, doubles as the array address
  typedef logic [`LLC_INDEX_W-1:0] index_t;

  // tag field of an address
  typedef logic [`LLC_TAG_W-1:0] tag_t;

  // ----------------------------------------
  // enums
  // ----------------------------------------

  // request modes, 2'b11 is not used
  typedef enum logic [1:0] {
    REQ_LOOKUP = 2'd0,
    REQ_STORE  = 2'd1,
    REQ_FLUSH  = 2'd2
  } tag_req_e;

  // decode state, busy while a result is pending
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } ctrl_state_e;

  // stored entry, 10 bits
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

//--- src/tag_sram_if.sv
// interface between decode, tag array and result stage: access side and read side
`default_nettype none

`include "llc_tag_params.svh"

interface tag_sram_if;

  // ----------------------------------------
  // access side, driven by decode
  // ----------------------------------------

  // per-way request and write enable
  llc_tag_pkg::way_t       req_ways;
  llc_tag_pkg::way_t       we_ways;
  // shared address and write data for all ways
  llc_tag_pkg::index_t     index;
  llc_tag_pkg::tag_entry_t wdata;
  // lookup tag and the ways taking part in the compare, both registered
  llc_tag_pkg::tag_t       cmp_tag;
  llc_tag_pkg::way_t       cmp_ways;

  // ----------------------------------------
  // read side, driven by the array
  // ----------------------------------------

  // registered entry of every way
  llc_tag_pkg::tag_entry_t [`LLC_WAYS-1:0] rd_entry;
  // compare result and flag vectors of the read entries
  llc_tag_pkg::way_t       hit_ways;
  llc_tag_pkg::way_t       val_ways;
  llc_tag_pkg::way_t       dit_ways;

  modport decode (
    output req_ways, we_ways, index, wdata, cmp_tag, cmp_ways
  );

  modport array (
    input  req_ways, we_ways, index, wdata, cmp_tag, cmp_ways,
    output rd_entry, hit_ways, val_ways, dit_ways
  );

  modport result (
    input  rd_entry, hit_ways, val_ways, dit_ways
  );

endinterface

`default_nettype wire

//--- src/tag_req_decode.sv
// request decode: handshake, busy state, operand registers, array access control
`default_nettype none

module tag_req_decode (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  valid_i,
  input  llc_tag_pkg::tag_req_e req_mode_i,
  input  llc_tag_pkg::way_t     way_i,
  input  llc_tag_pkg::index_t   index_i,
  input  logic                  dirty_i,
  input  llc_tag_pkg::tag_t     tag_i,
  input  llc_tag_pkg::way_t     spm_lock_i,
  input  logic                  ready_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output logic                  flush_o,
  output logic                  consume_o,
  // registered flush way for the result stage
  output llc_tag_pkg::way_t     way_o,
  tag_sram_if.decode            sram
);

  // control state
  llc_tag_pkg::ctrl_state_e state_q, state_d;
  llc_tag_pkg::tag_req_e    mode_q;
  llc_tag_pkg::way_t        cmp_ways_q;
  // operands of the pending item
  llc_tag_pkg::index_t      index_q;
  llc_tag_pkg::way_t        way_q;
  llc_tag_pkg::tag_t        cmp_tag_q;

  logic transfer;
  logic accept;
  logic load;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // result pending exactly while busy
  assign valid_o   = (state_q == llc_tag_pkg::ST_BUSY);
  assign transfer  = valid_o & ready_i;
  assign flush_o   = (mode_q == llc_tag_pkg::REQ_FLUSH);
  assign consume_o = transfer & (mode_q == llc_tag_pkg::REQ_LOOKUP);

  // idle takes anything
  // busy only overlaps a lookup or store with a lookup result leaving,
  // a flush result needs the array for its write-back
  always_comb begin : proc_ready
    if (!valid_o) begin
      ready_o = 1'b1;
    end else begin
      ready_o = consume_o &
                (req_mode_i inside {llc_tag_pkg::REQ_LOOKUP, llc_tag_pkg::REQ_STORE});
    end
  end

  assign accept = valid_i & ready_o;
  // only lookup and flush leave a pending item behind
  assign load   = accept &
                  (req_mode_i inside {llc_tag_pkg::REQ_LOOKUP, llc_tag_pkg::REQ_FLUSH});

  // ----------------------------------------
  // next state and array access
  // ----------------------------------------

  always_comb begin : proc_access
    state_d       = state_q;
    sram.req_ways = '0;
    sram.we_ways  = '0;
    sram.index    = index_i;
    // a stored entry is always valid
    sram.wdata    = '{valid: 1'b1, dirty: dirty_i, tag: tag_i};

    // result leaves, go idle unless a new lookup comes in below
    if (transfer) begin
      state_d = llc_tag_pkg::ST_IDLE;
      // flushed way gets an all-zero entry, i.e. invalid
      if (flush_o) begin
        sram.req_ways = way_q;
        sram.we_ways  = way_q;
        sram.index    = index_q;
        sram.wdata    = '0;
      end
    end

    if (accept) begin
      case (req_mode_i)
        // write in the acceptance cycle, no result
        llc_tag_pkg::REQ_STORE: begin
          sram.req_ways = way_i;
          sram.we_ways  = way_i;
        end
        // read all unlocked ways, compare next cycle
        llc_tag_pkg::REQ_LOOKUP: begin
          sram.req_ways = ~spm_lock_i;
          state_d       = llc_tag_pkg::ST_BUSY;
        end
        // read only the named way
        llc_tag_pkg::REQ_FLUSH: begin
          sram.req_ways = way_i;
          state_d       = llc_tag_pkg::ST_BUSY;
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk_i) begin : proc_ctrl
    if (reset_i) begin
      state_q    <= llc_tag_pkg::ST_IDLE;
      mode_q     <= llc_tag_pkg::REQ_LOOKUP;
      cmp_ways_q <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        mode_q     <= req_mode_i;
        // flush takes no part in the hit compare
        cmp_ways_q <= (req_mode_i == llc_tag_pkg::REQ_LOOKUP) ? ~spm_lock_i : '0;
      end
    end
  end

  // operands, kept until the result transfers
  always_ff @(posedge clk_i) begin : proc_operands
    if (load) begin
      index_q   <= index_i;
      way_q     <= way_i;
      cmp_tag_q <= tag_i;
    end
  end

  assign way_o         = way_q;
  assign sram.cmp_tag  = cmp_tag_q;
  assign sram.cmp_ways = cmp_ways_q;

endmodule

`default_nettype wire

//--- src/tag_way_array.sv
// tag array: per-way entry storage, registered read data, tag compare
`default_nettype none

`include "llc_tag_params.svh"

module tag_way_array (
  input  logic       clk_i,
  input  logic       reset_i,
  tag_sram_if.array  sram
);

  localparam int unsigned NumSets = 2 ** `LLC_INDEX_W;

  // ----------------------------------------
  // one storage column per way
  // ----------------------------------------

  for (genvar w = 0; w < `LLC_WAYS; w++) begin : g_way
    llc_tag_pkg::tag_entry_t mem [NumSets];
    llc_tag_pkg::tag_entry_t rd_q;
    logic                    wr_en;
    logic                    rd_en;
    logic                    tag_eq;

    assign wr_en = sram.req_ways[w] & sram.we_ways[w];
    assign rd_en = sram.req_ways[w] & ~sram.we_ways[w];

    // reset leaves every entry invalid
    always_ff @(posedge clk_i) begin : proc_store
      if (reset_i) begin
        for (int unsigned i = 0; i < NumSets; i++) begin
          mem[i] <= '0;
        end
      end else if (wr_en) begin
        mem[sram.index] <= sram.wdata;
      end
    end

    // read register holds when the way is not read,
    // keeps a stalled result stable
    always_ff @(posedge clk_i) begin : proc_read
      if (rd_en) begin
        rd_q <= mem[sram.index];
      end
    end

    // compare against the registered lookup tag
    assign tag_eq = (rd_q.tag == sram.cmp_tag);

    // hit only in valid ways that take part in the lookup
    assign sram.hit_ways[w] = sram.cmp_ways[w] & rd_q.valid & tag_eq;
    assign sram.val_ways[w] = rd_q.valid;
    assign sram.dit_ways[w] = rd_q.dirty;
    assign sram.rd_entry[w] = rd_q;
  end

endmodule

`default_nettype wire

//--- src/tag_victim_select.sv
// result stage: hit or victim way, eviction flag, round-robin pointer, tag mux
`default_nettype none

`include "llc_tag_params.svh"

module tag_victim_select (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               flush_i,
  input  logic               consume_i,
  input  llc_tag_pkg::way_t  way_i,
  input  llc_tag_pkg::way_t  spm_lock_i,
  tag_sram_if.result         sram,
  output llc_tag_pkg::way_t  way_o,
  output logic               hit_o,
  output logic               evict_o,
  output llc_tag_pkg::tag_t  tag_o,
  output logic               dirty_o
);

  // one-hot round-robin pointer
  llc_tag_pkg::way_t rr_q, rr_d;

  logic              any_hit;
  llc_tag_pkg::way_t free_ways;
  llc_tag_pkg::way_t first_free;
  llc_tag_pkg::way_t victim;
  logic              rr_step;

  assign any_hit   = |sram.hit_ways;
  // unlocked and invalid, usable without eviction
  assign free_ways = ~spm_lock_i & ~sram.val_ways;

  // ----------------------------------------
  // victim choice
  // ----------------------------------------

  // lowest index wins, scan downwards so it is written last
  always_comb begin : proc_first_free
    first_free = '0;
    for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        first_free    = '0;
        first_free[w] = 1'b1;
      end
    end
  end

  // pointer only when no unlocked way is free
  assign victim = (|free_ways) ? first_free : rr_q;

  // output select
  always_comb begin : proc_result
    if (flush_i) begin
      way_o   = way_i;
      hit_o   = 1'b0;
      evict_o = |(way_i & sram.val_ways & sram.dit_ways);
    end else if (any_hit) begin
      way_o   = sram.hit_ways;
      hit_o   = 1'b1;
      evict_o = 1'b0;
    end else begin
      way_o   = victim;
      hit_o   = 1'b0;
      evict_o = |(victim & sram.val_ways & sram.dit_ways);
    end
  end

  // tag mux on the selected way
  always_comb begin : proc_tag_mux
    tag_o   = '0;
    dirty_o = 1'b0;
    for (int unsigned w = 0; w < `LLC_WAYS; w++) begin
      if (way_o[w]) begin
        tag_o   = sram.rd_entry[w].tag;
        dirty_o = sram.rd_entry[w].dirty;
      end
    end
  end

  // ----------------------------------------
  // round-robin pointer
  // ----------------------------------------

  // next unlocked way after the current one, wrapping around
  always_comb begin : proc_rr_next
    llc_tag_pkg::way_t cand;
    logic              found;
    rr_d  = rr_q;
    found = 1'b0;
    for (int k = 1; k <= `LLC_WAYS; k++) begin
      cand = (rr_q << k) | (rr_q >> (`LLC_WAYS - k));
      if (!found && (|(cand & ~spm_lock_i))) begin
        rr_d  = cand;
        found = 1'b1;
      end
    end
  end

  // advance only on a taken miss that had to evict
  assign rr_step = consume_i & ~any_hit & ~(|free_ways);

  always_ff @(posedge clk_i) begin : proc_rr
    if (reset_i) begin
      rr_q <= llc_tag_pkg::way_t'(1);
    end else if (rr_step) begin
      rr_q <= rr_d;
    end
  end

endmodule

`default_nettype wire

//--- src/llc_tag_store.sv
// tag store top: decode, tag array and result stage behind plain ports
`default_nettype none

module llc_tag_store (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // scratchpad ways, kept out of lookup and victim choice
  input  llc_tag_pkg::way_t     spm_lock_i,
  // ----------------------------------------
  // request side
  // ----------------------------------------
  input  logic                  valid_i,
  output logic                  ready_o,
  input  llc_tag_pkg::tag_req_e req_mode_i,
  input  llc_tag_pkg::way_t     way_i,
  input  llc_tag_pkg::index_t   index_i,
  input  logic                  dirty_i,
  input  llc_tag_pkg::tag_t     tag_i,
  // ----------------------------------------
  // result side
  // ----------------------------------------
  output llc_tag_pkg::way_t     way_o,
  output logic                  hit_o,
  output logic                  evict_o,
  output llc_tag_pkg::tag_t     tag_o,
  output logic                  dirty_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  // decode to result stage
  logic              flush;
  logic              consume;
  llc_tag_pkg::way_t flush_way;

  tag_sram_if u_sram_if ();

  // accepts requests, drives the array accesses
  tag_req_decode u_req_decode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (valid_i),
    .req_mode_i (req_mode_i),
    .way_i      (way_i),
    .index_i    (index_i),
    .dirty_i    (dirty_i),
    .tag_i      (tag_i),
    .spm_lock_i (spm_lock_i),
    .ready_i    (ready_i),
    .ready_o    (ready_o),
    .valid_o    (valid_o),
    .flush_o    (flush),
    .consume_o  (consume),
    .way_o      (flush_way),
    .sram       (u_sram_if.decode)
  );

  // storage and compare, read data one cycle later
  tag_way_array u_way_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .sram    (u_sram_if.array)
  );

  // combinational result from the array read side
  tag_victim_select u_victim_select (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (flush),
    .consume_i  (consume),
    .way_i      (flush_way),
    .spm_lock_i (spm_lock_i),
    .sram       (u_sram_if.result),
    .way_o      (way_o),
    .hit_o      (hit_o),
    .evict_o    (evict_o),
    .tag_o      (tag_o),
    .dirty_o    (dirty_o)
  );

endmodule

`default_nettype wire

//--- verif/llc_tag_store_properties.sv
// bound assertions: result hold under back-pressure, one-hot way, reset state, lock mask
`default_nettype none

module llc_tag_store_properties (
  input logic              clk_i,
  input logic              reset_i,
  input llc_tag_pkg::way_t spm_lock_i,
  input logic              valid_o,
  input logic              ready_i,
  input llc_tag_pkg::way_t way_o,
  input logic              hit_o,
  input logic              evict_o,
  input llc_tag_pkg::tag_t tag_o,
  input logic              dirty_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // result handshake
  // ----------------------------------------

  // a stalled result stays up
  a_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      valid_o && !ready_i |=> valid_o)
    else $error("valid_o dropped before ready_i");

  // and its fields with it
  a_fields_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      valid_o && !ready_i |=> $stable({way_o, hit_o, evict_o, tag_o, dirty_o}))
    else $error("result fields changed while the result was stalled");

  // ----------------------------------------
  // result shape and reset
  // ----------------------------------------

  // exactly one way named per result
  a_way_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      valid_o |-> $onehot(way_o))
    else $error("way_o is not one-hot while valid_o is high");

  a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else $error("valid_o high right after reset");

  // at least one way left for the cache
  a_lock_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
      !(&spm_lock_i))
    else $error("all ways locked as scratchpad");

endmodule

`default_nettype wire

//--- verif/tb_llc_tag_store.sv
// tag store testbench with clock, reset, stimulus table, reference model and compare tasks
`default_nettype none

`include "llc_tag_params.svh"

module tb_llc_tag_store;
  timeunit 1ns;
  timeprecision 1ps;

  // one request and, for lookup or flush, its expected result
  typedef struct {
    llc_tag_pkg::tag_req_e mode;
    llc_tag_pkg::way_t     way;
    llc_tag_pkg::index_t   index;
    logic                  dirty;
    llc_tag_pkg::tag_t     tag;
    llc_tag_pkg::way_t     lock;
    llc_tag_pkg::way_t     exp_way;
    logic                  exp_hit;
    logic                  exp_evict;
    llc_tag_pkg::tag_t     exp_tag;
    logic                  exp_dirty;
  } test_row_t;

  localparam int NumRows   = 34;
  localparam int NumSets   = 2 ** `LLC_INDEX_W;
  // random back-pressure from this row on
  localparam int StallFrom = 18;
  localparam int WaitLimit = 200;

  localparam llc_tag_pkg::tag_req_e LK = llc_tag_pkg::REQ_LOOKUP;
  localparam llc_tag_pkg::tag_req_e ST = llc_tag_pkg::REQ_STORE;
  localparam llc_tag_pkg::tag_req_e FL = llc_tag_pkg::REQ_FLUSH;
  localparam llc_tag_pkg::way_t     W0 = 4'b0001;
  localparam llc_tag_pkg::way_t     W1 = 4'b0010;
  localparam llc_tag_pkg::way_t     W2 = 4'b0100;
  localparam llc_tag_pkg::way_t     W3 = 4'b1000;

  logic                  clk_i;
  logic                  reset_i;
  llc_tag_pkg::way_t     spm_lock_i;
  logic                  valid_i;
  logic                  ready_o;
  llc_tag_pkg::tag_req_e req_mode_i;
  llc_tag_pkg::way_t     way_i;
  llc_tag_pkg::index_t   index_i;
  logic                  dirty_i;
  llc_tag_pkg::tag_t     tag_i;
  llc_tag_pkg::way_t     way_o;
  logic                  hit_o;
  logic                  evict_o;
  llc_tag_pkg::tag_t     tag_o;
  logic                  dirty_o;
  logic                  valid_o;
  logic                  ready_i;

  test_row_t tbl [NumRows];
  // rows whose result is still outstanding in request order
  int        pending_q [$];
  logic      stall_en;
  logic      end_reported;
  // result seen stalled on the last edge
  logic      hold_pending;
  llc_tag_pkg::way_t held_way;
  logic      held_hit;
  logic      held_evict;
  llc_tag_pkg::tag_t held_tag;
  logic      held_dirty;

  llc_tag_store u_llc_tag_store (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .spm_lock_i (spm_lock_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .req_mode_i (req_mode_i),
    .way_i      (way_i),
    .index_i    (index_i),
    .dirty_i    (dirty_i),
    .tag_i      (tag_i),
    .way_o      (way_o),
    .hit_o      (hit_o),
    .evict_o    (evict_o),
    .tag_o      (tag_o),
    .dirty_o    (dirty_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i)
  );

  bind llc_tag_store llc_tag_store_properties u_properties (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .spm_lock_i (spm_lock_i),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .way_o      (way_o),
    .hit_o      (hit_o),
    .evict_o    (evict_o),
    .tag_o      (tag_o),
    .dirty_o    (dirty_o)
  );

  initial begin : proc_clock
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------

  // columns mode way index dirty tag lock then expected way hit evict tag dirty
  task automatic fill_table();
    // store then hit while another tag misses into way 0
    tbl[0]  = '{ST, W1, 4'd1, 1'b0, 8'h3a, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[1]  = '{LK, W0, 4'd1, 1'b0, 8'h3a, 4'h0, W1, 1'b1, 1'b0, 8'h3a, 1'b0};
    tbl[2]  = '{LK, W0, 4'd1, 1'b0, 8'h3b, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    // way 0 locked so it is skipped as victim and never hits
    tbl[3]  = '{LK, W0, 4'd2, 1'b0, 8'h11, 4'h1, W1, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[4]  = '{ST, W0, 4'd2, 1'b1, 8'h22, 4'h1, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[5]  = '{LK, W0, 4'd2, 1'b0, 8'h22, 4'h1, W1, 1'b0, 1'b0, 8'h00, 1'b0};
    // full set with way 2 locked gives round robin order 0 1 3 0
    tbl[6]  = '{ST, W0, 4'd3, 1'b1, 8'h40, 4'h4, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[7]  = '{ST, W1, 4'd3, 1'b0, 8'h41, 4'h4, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[8]  = '{ST, W3, 4'd3, 1'b1, 8'h43, 4'h4, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[9]  = '{LK, W0, 4'd3, 1'b0, 8'h50, 4'h4, W0, 1'b0, 1'b1, 8'h40, 1'b1};
    tbl[10] = '{LK, W0, 4'd3, 1'b0, 8'h51, 4'h4, W1, 1'b0, 1'b0, 8'h41, 1'b0};
    tbl[11] = '{LK, W0, 4'd3, 1'b0, 8'h52, 4'h4, W3, 1'b0, 1'b1, 8'h43, 1'b1};
    tbl[12] = '{LK, W0, 4'd3, 1'b0, 8'h41, 4'h4, W1, 1'b1, 1'b0, 8'h41, 1'b0};
    tbl[13] = '{LK, W0, 4'd3, 1'b0, 8'h53, 4'h4, W0, 1'b0, 1'b1, 8'h40, 1'b1};
    // flush of a dirty way and then it reads back invalid
    tbl[14] = '{FL, W3, 4'd3, 1'b0, 8'h00, 4'h4, W3, 1'b0, 1'b1, 8'h43, 1'b1};
    tbl[15] = '{FL, W3, 4'd3, 1'b0, 8'h00, 4'h4, W3, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[16] = '{LK, W0, 4'd3, 1'b0, 8'h43, 4'h4, W3, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[17] = '{FL, W1, 4'd3, 1'b0, 8'h00, 4'h4, W1, 1'b0, 1'b0, 8'h41, 1'b0};
    // stalls and overlapped lookups
    tbl[18] = '{ST, W2, 4'd5, 1'b1, 8'h60, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[19] = '{LK, W0, 4'd5, 1'b0, 8'h60, 4'h0, W2, 1'b1, 1'b0, 8'h60, 1'b1};
    tbl[20] = '{LK, W0, 4'd5, 1'b0, 8'h61, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[21] = '{ST, W0, 4'd5, 1'b0, 8'h61, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[22] = '{LK, W0, 4'd5, 1'b0, 8'h61, 4'h0, W0, 1'b1, 1'b0, 8'h61, 1'b0};
    tbl[23] = '{LK, W0, 4'd5, 1'b0, 8'h60, 4'h0, W2, 1'b1, 1'b0, 8'h60, 1'b1};
    tbl[24] = '{LK, W0, 4'd5, 1'b0, 8'h62, 4'h0, W1, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[25] = '{ST, W1, 4'd5, 1'b1, 8'h62, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[26] = '{ST, W3, 4'd5, 1'b0, 8'h63, 4'h0, W0, 1'b0, 1'b0, 8'h00, 1'b0};
    tbl[27] = '{LK, W0, 4'd5, 1'b0, 8'h64, 4'h0, W1, 1'b0, 1'b1, 8'h62, 1'b1};
    tbl[28] = '{LK, W0, 4'd5, 1'b0, 8'h65, 4'h0, W2, 1'b0, 1'b1, 8'h60, 1'b1};
    tbl[29] = '{LK, W0, 4'd5, 1'b0, 8'h63, 4'h0, W3, 1'b1, 1'b0, 8'h63, 1'b0};
    tbl[30] = '{LK, W0, 4'd5, 1'b0, 8'h66, 4'h0, W3, 1'b0, 1'b0, 8'h63, 1'b0};
    tbl[31] = '{LK, W0, 4'd1, 1'b0, 8'h3a, 4'h0, W1, 1'b1, 1'b0, 8'h3a, 1'b0};
    tbl[32] = '{FL, W2, 4'd5, 1'b0, 8'h00, 4'h0, W2, 1'b0, 1'b1, 8'h60, 1'b1};
    tbl[33] = '{LK, W0, 4'd5, 1'b0, 8'h60, 4'h0, W2, 1'b0, 1'b0, 8'h00, 1'b0};
  endtask

  // ----------------------------------------
  // failure report and compare tasks
  // ----------------------------------------

  task automatic abort_run(input string why);
    end_reported = 1'b1;
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_way(input string name, input llc_tag_pkg::way_t exp,
                           input llc_tag_pkg::way_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input llc_tag_pkg::tag_t exp,
                           input llc_tag_pkg::tag_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // ----------------------------------------
  // reference model of entries and pointer
  // ----------------------------------------

  function automatic llc_tag_pkg::way_t way_bit(input int w);
    way_bit = llc_tag_pkg::way_t'(1) << w;
  endfunction

  function automatic bit has_way(input llc_tag_pkg::way_t v, input int w);
    has_way = |(v & way_bit(w));
  endfunction

  function automatic bit row_matches(input test_row_t r, input int w, input logic hit,
                                     input llc_tag_pkg::tag_entry_t e);
    row_matches = (r.exp_way == way_bit(w)) && (r.exp_hit == hit) &&
                  (r.exp_evict == (!hit && e.valid && e.dirty)) &&
                  (r.exp_tag == e.tag) && (r.exp_dirty == e.dirty);
  endfunction

  // replays the table in order and confirms every expected result
  task automatic check_table();
    llc_tag_pkg::tag_entry_t mem [`LLC_WAYS][NumSets];
    llc_tag_pkg::tag_entry_t e;
    test_row_t               r;
    int                      rr;
    int                      pick;
    int                      hit_w;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        mem[w][s] = '0;
      end
    end
    rr = 0;
    for (int i = 0; i < NumRows; i++) begin
      r     = tbl[i];
      pick  = -1;
      hit_w = -1;
      for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
        if (r.mode == FL && has_way(r.way, w)) pick = w;
        if (r.mode == ST && has_way(r.way, w)) mem[w][r.index] = '{1'b1, r.dirty, r.tag};
        if (r.mode == LK && !has_way(r.lock, w)) begin
          e = mem[w][r.index];
          if (e.valid && e.tag == r.tag) hit_w = w;
          if (!e.valid) pick = w;
        end
      end
      if (r.mode == LK && hit_w >= 0) begin
        pick = hit_w;
      end else if (r.mode == LK && pick < 0) begin
        // with no free way evict at the pointer and step past locked ways
        pick = rr;
        do begin
          rr = (rr + 1) % `LLC_WAYS;
        end while (has_way(r.lock, rr));
      end
      if (r.mode != ST) begin
        e = mem[pick][r.index];
        if (!row_matches(r, pick, hit_w >= 0, e)) begin
          abort_run($sformatf("table row %0d does not agree with the reference model", i));
        end
        if (r.mode == FL) mem[pick][r.index] = '0;
      end
    end
  endtask

  // ----------------------------------------
  // bounded waits
  // ----------------------------------------

  // returns on the edge where the driven request is taken
  task automatic wait_accept(input int row);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    while (!ready_o) begin
      cnt++;
      if (cnt > WaitLimit) abort_run($sformatf("ready_o never rose for row %0d", row));
      @(posedge clk_i);
    end
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    while (valid_o) begin
      cnt++;
      if (cnt > WaitLimit) abort_run("the DUT did not go idle before a lock change");
      @(posedge clk_i);
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (pending_q.size() != 0) begin
      cnt++;
      if (cnt > WaitLimit) abort_run("results still missing at the end of the table");
      @(posedge clk_i);
    end
  endtask

  // ----------------------------------------
  // request side
  // ----------------------------------------

  initial begin : proc_main
    llc_tag_pkg::way_t cur_lock;
    reset_i      = 1'b1;
    spm_lock_i   = '0;
    valid_i      = 1'b0;
    req_mode_i   = LK;
    way_i        = '0;
    index_i      = '0;
    dirty_i      = 1'b0;
    tag_i        = '0;
    ready_i      = 1'b1;
    stall_en     = 1'b0;
    end_reported = 1'b0;
    hold_pending = 1'b0;
    cur_lock     = '0;
    void'($urandom(32'h63c2));
    fill_table();
    check_table();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    for (int i = 0; i < NumRows; i++) begin
      if (i == StallFrom) stall_en <= 1'b1;
      // the lock feeds the pending result, so it only moves while idle
      if (tbl[i].lock != cur_lock) begin
        valid_i <= 1'b0;
        wait_idle();
        cur_lock = tbl[i].lock;
      end
      spm_lock_i <= tbl[i].lock;
      valid_i    <= 1'b1;
      req_mode_i <= tbl[i].mode;
      way_i      <= tbl[i].way;
      index_i    <= tbl[i].index;
      dirty_i    <= tbl[i].dirty;
      tag_i      <= tbl[i].tag;
      wait_accept(i);
      if (tbl[i].mode != ST) pending_q.push_back(i);
    end
    valid_i <= 1'b0;
    wait_drain();
    @(posedge clk_i);
    if (!valid_o) begin
      end_reported = 1'b1;
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run("valid_o still high after the last result");
    end
  end

  // ----------------------------------------
  // result side
  // ----------------------------------------

  always @(posedge clk_i) begin : proc_result_side
    int row;
    if (!reset_i) begin
      // a stalled result must come back unchanged
      if (hold_pending) begin
        if (!valid_o) abort_run("valid_o dropped while the result was stalled");
        check_way("held way_o", held_way, way_o);
        check_flag("held hit_o", held_hit, hit_o);
        check_flag("held evict_o", held_evict, evict_o);
        check_tag("held tag_o", held_tag, tag_o);
        check_flag("held dirty_o", held_dirty, dirty_o);
      end
      // a stalled result keeps the request side closed
      if (valid_o && !ready_i && ready_o) begin
        abort_run("ready_o high while a result was stalled");
      end
      hold_pending = valid_o & ~ready_i;
      held_way     = way_o;
      held_hit     = hit_o;
      held_evict   = evict_o;
      held_tag     = tag_o;
      held_dirty   = dirty_o;
      if (valid_o && ready_i) begin
        if (pending_q.size() == 0) abort_run("a result came out with no request outstanding");
        row = pending_q.pop_front();
        check_way($sformatf("row %0d way_o", row), tbl[row].exp_way, way_o);
        check_flag($sformatf("row %0d hit_o", row), tbl[row].exp_hit, hit_o);
        check_flag($sformatf("row %0d evict_o", row), tbl[row].exp_evict, evict_o);
        check_tag($sformatf("row %0d tag_o", row), tbl[row].exp_tag, tag_o);
        check_flag($sformatf("row %0d dirty_o", row), tbl[row].exp_dirty, dirty_o);
      end
    end
    // roughly one stall cycle in three
    ready_i <= stall_en ? ($urandom_range(2, 0) != 0) : 1'b1;
  end

  // run stopped by an assertion
  final begin : proc_final
    if (!end_reported) begin
      $display("TESTS FAILED");
    end
  end

endmodule

`default_nettype wire

//--- llc_tag_store.f
+incdir+include
src/llc_tag_pkg.sv
src/tag_sram_if.sv
src/tag_req_decode.sv
src/tag_way_array.sv
src/tag_victim_select.sv
src/llc_tag_store.sv
verif/llc_tag_store_properties.sv
verif/tb_llc_tag_store.sv

//--- Makefile
# Verilator build and run of the tag store testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_llc_tag_store
FILELIST := llc_tag_store.f
OBJ_DIR  := obj_dir
LOG      := sim.log
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(wildcard src/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail is decided by the log, not by the exit status
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
